//--- project.f
spi_pkg.sv
spi_clk_if.sv
spi_queue.sv
spi_sclk_gen.sv
spi_shift_engine.sv
spi_master.sv
spi_master_props.sv
tb_spi_master.sv

//--- spi_clk_if.sv
`timescale 1ns/1ns

interface spi_clk_if;

  logic run;   // engine wants sclk running.
  logic sclk;
  logic rise;  // one clk wide, same cycle sclk goes high.
  logic fall;  // one clk wide, same cycle sclk goes low.

  modport eng (
    output run,
    input  sclk,
    input  rise,
    input  fall
  );

  modport gen (
    input  run,
    output sclk,
    output rise,
    output fall
  );

endinterface

//--- spi_master.sv
`timescale 1ns/1ns

module spi_master #(
  parameter int CLK_DIV     = 4,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  spi_pkg::spi_cmd_t   cmd_in,
  input  logic                cmd_vld,
  output logic                cmd_rdy,
  output spi_pkg::spi_rdata_t read_data,
  output logic                read_vld,
  input  logic                read_rdy,
  output logic                sclk,
  output logic                cs_n,
  output logic                mosi,
  input  logic                miso
);

  import spi_pkg::*;

  spi_cmd_t   eng_cmd_data;
  logic       eng_cmd_vld;
  logic       eng_cmd_rdy;
  spi_rdata_t eng_rd_data;
  logic       eng_rd_vld;
  logic       eng_rd_rdy;

  spi_clk_if ck_if ();

  // ==========================================================================
  // host side queues
  // ==========================================================================

  spi_queue #(
    .T           (spi_cmd_t),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_cmd_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .push_data (cmd_in),
    .push_vld  (cmd_vld),
    .push_rdy  (cmd_rdy),
    .pop_data  (eng_cmd_data),
    .pop_vld   (eng_cmd_vld),
    .pop_rdy   (eng_cmd_rdy)
  );

  spi_queue #(
    .T           (spi_rdata_t),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_rd_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .push_data (eng_rd_data),
    .push_vld  (eng_rd_vld),
    .push_rdy  (eng_rd_rdy),
    .pop_data  (read_data),
    .pop_vld   (read_vld),
    .pop_rdy   (read_rdy)
  );

  // ==========================================================================
  // serial side
  // ==========================================================================

  spi_sclk_gen #(
    .CLK_DIV (CLK_DIV)
  ) u_sclk_gen (
    .clk   (clk),
    .rst_n (rst_n),
    .ck    (ck_if.gen)
  );

  spi_shift_engine #(
    .CLK_DIV (CLK_DIV)
  ) u_engine (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_data (eng_cmd_data),
    .cmd_vld  (eng_cmd_vld),
    .cmd_rdy  (eng_cmd_rdy),
    .rd_data  (eng_rd_data),
    .rd_vld   (eng_rd_vld),
    .rd_rdy   (eng_rd_rdy),
    .ck       (ck_if.eng),
    .cs_n     (cs_n),
    .mosi     (mosi),
    .miso     (miso)
  );

  assign sclk = ck_if.sclk;

endmodule

//--- spi_master_props.sv
`timescale 1ns/1ns

module spi_master_props (
  input logic                clk,
  input logic                rst_n,
  input spi_pkg::spi_rdata_t read_data,
  input logic                read_vld,
  input logic                read_rdy,
  input logic                sclk,
  input logic                cs_n,
  input logic                mosi
);

  int fail_count = 0;  // failed assertions so far.

  // no clock pulses outside a frame.
  a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n)
    cs_n |-> !sclk)
    else
    begin
      fail_count++;
      $error("sclk high while cs_n is high");
    end

  a_read_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (read_vld && !read_rdy) |=> (read_vld && $stable(read_data)))
    else
    begin
      fail_count++;
      $error("read port changed while stalled");
    end

  // in mode 0 data moves only while sclk is low.
  a_mosi_stable: assert property (@(posedge clk) disable iff (!rst_n)
    sclk |-> $stable(mosi))
    else
    begin
      fail_count++;
      $error("mosi changed while sclk is high");
    end

endmodule

bind spi_master spi_master_props u_props (.*);

//--- spi_pkg.sv
package spi_pkg;

  // ==========================================================================
  // frame geometry
  // ==========================================================================

  localparam int CMD_WIDTH  = 12;  // bits shifted out per command.
  localparam int READ_WIDTH = 8;   // bits captured after a read command.
  localparam int RW_BIT     = 11;  // 1 = write, 0 = read.

  typedef logic [CMD_WIDTH-1:0]  spi_cmd_t;
  typedef logic [READ_WIDTH-1:0] spi_rdata_t;

  // ==========================================================================
  // shift engine states
  // ==========================================================================

  typedef enum logic [2:0] {
    IDLE,        // waiting for a command.
    LOAD,        // cs_n low, first bit on mosi.
    SHIFT_CMD,   // command bits out on falls.
    SHIFT_READ,  // read tail, miso on rises.
    FINISH,      // cs_n high, push read byte.
    GAP          // minimum cs_n high time.
  } eng_state_t;

endpackage

//--- spi_queue.sv
`timescale 1ns/1ns

module spi_queue #(
  parameter type T           = logic [7:0],
  parameter int  QUEUE_DEPTH = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  T     push_data,
  input  logic push_vld,
  output logic push_rdy,
  output T     pop_data,
  output logic pop_vld,
  input  logic pop_rdy
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  T                 mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] rd_ptr_nxt;
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;

  assign push_rdy   = (count != (PTR_W+1)'(QUEUE_DEPTH));
  assign pop_vld    = (count != '0);
  assign push       = push_vld && push_rdy;
  assign pop        = pop_vld && pop_rdy;
  assign rd_ptr_nxt = pop ? rd_ptr + 1'b1 : rd_ptr;  // head after this cycle.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      rd_ptr <= rd_ptr_nxt;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head register, bypassed when the push lands on the new head slot
  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_data;
    if (push && (wr_ptr == rd_ptr_nxt))
      pop_data <= push_data;
    else
      pop_data <= mem[rd_ptr_nxt];
  end

endmodule

//--- spi_sclk_gen.sv
`timescale 1ns/1ns

module spi_sclk_gen #(
  parameter int CLK_DIV = 4
) (
  input logic    clk,
  input logic    rst_n,
  spi_clk_if.gen ck
);

  localparam int CNT_W = $clog2(CLK_DIV + 1);

  logic [CNT_W-1:0] cnt;
  logic             expire;

  assign expire = (cnt == CNT_W'(1));  // half period done.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt     <= CNT_W'(CLK_DIV);
      ck.sclk <= 1'b0;
      ck.rise <= 1'b0;
      ck.fall <= 1'b0;
    end
    else if (!ck.run)
    begin
      cnt     <= CNT_W'(CLK_DIV);  // park, next run starts a full half period.
      ck.sclk <= 1'b0;
      ck.rise <= 1'b0;
      ck.fall <= 1'b0;
    end
    else if (expire)
    begin
      cnt     <= CNT_W'(CLK_DIV);
      ck.sclk <= ~ck.sclk;
      ck.rise <= ~ck.sclk;  // strobe matches the new level.
      ck.fall <= ck.sclk;
    end
    else
    begin
      cnt     <= cnt - 1'b1;
      ck.rise <= 1'b0;
      ck.fall <= 1'b0;
    end
  end

endmodule

//--- spi_shift_engine.sv
`timescale 1ns/1ns

module spi_shift_engine #(
  parameter int CLK_DIV = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  spi_pkg::spi_cmd_t   cmd_data,
  input  logic                cmd_vld,
  output logic                cmd_rdy,
  output spi_pkg::spi_rdata_t rd_data,
  output logic                rd_vld,
  input  logic                rd_rdy,
  spi_clk_if.eng              ck,
  output logic                cs_n,
  output logic                mosi,
  input  logic                miso
);

  import spi_pkg::*;

  localparam int BIT_MAX = (CMD_WIDTH > READ_WIDTH) ? CMD_WIDTH : READ_WIDTH;
  localparam int CNT_MAX = (CLK_DIV > BIT_MAX) ? CLK_DIV : BIT_MAX;
  localparam int CNT_W   = $clog2(CNT_MAX + 1);

  eng_state_t       state;
  spi_cmd_t         cmd_sr;
  spi_rdata_t       rd_sr;
  logic [CNT_W-1:0] bit_cnt;  // bits, then gap cycles.
  logic             is_read;
  logic             cmd_take;

  // a read is only taken while its result has a slot waiting
  assign cmd_rdy  = (state == IDLE) && (cmd_data[RW_BIT] || rd_rdy);
  assign cmd_take = cmd_vld && cmd_rdy;
  assign rd_vld   = (state == FINISH) && is_read;
  assign rd_data  = rd_sr;

  // ==========================================================================
  // transfer sequencing
  // ==========================================================================

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= IDLE;
      cs_n    <= 1'b1;
      mosi    <= 1'b0;
      ck.run  <= 1'b0;
      bit_cnt <= '0;
      is_read <= 1'b0;
    end
    else
    begin
      case (state)
        IDLE:
          if (cmd_take)
          begin
            is_read <= !cmd_data[RW_BIT];
            state   <= LOAD;
          end
        LOAD:
        begin
          cs_n    <= 1'b0;
          mosi    <= cmd_sr[CMD_WIDTH-1];  // set up before first rise.
          ck.run  <= 1'b1;
          bit_cnt <= '0;
          state   <= SHIFT_CMD;
        end
        SHIFT_CMD:
          if (ck.fall)
          begin
            if (bit_cnt == CNT_W'(CMD_WIDTH - 1))
            begin
              bit_cnt <= '0;
              if (is_read)
                state <= SHIFT_READ;
              else
              begin
                ck.run <= 1'b0;
                state  <= FINISH;
              end
            end
            else
            begin
              mosi    <= cmd_sr[CMD_WIDTH-1];
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        SHIFT_READ:
          if (ck.rise)
            bit_cnt <= bit_cnt + 1'b1;
          else if (ck.fall && (bit_cnt == CNT_W'(READ_WIDTH)))
          begin
            ck.run <= 1'b0;  // sclk already back low.
            state  <= FINISH;
          end
        FINISH:
        begin
          cs_n    <= 1'b1;
          bit_cnt <= '0;
          state   <= GAP;
        end
        GAP:
          if (bit_cnt == CNT_W'(CLK_DIV - 1))
            state <= IDLE;
          else
            bit_cnt <= bit_cnt + 1'b1;
        default:
          state <= IDLE;
      endcase
    end
  end

  // shift registers, msb first both ways
  always_ff @(posedge clk)
  begin
    if (cmd_take)
      cmd_sr <= cmd_data;
    else if ((state == LOAD) || ((state == SHIFT_CMD) && ck.fall))
      cmd_sr <= {cmd_sr[CMD_WIDTH-2:0], 1'b0};
    if ((state == SHIFT_READ) && ck.rise)
      rd_sr <= {rd_sr[READ_WIDTH-2:0], miso};
  end

endmodule

//--- tb_spi_master.sv
`timescale 1ns/1ns

module tb_spi_master;

  import spi_pkg::*;

  localparam int CLK_DIV  = 4;
  localparam int READ_CYC = (CMD_WIDTH + READ_WIDTH) * 2 * CLK_DIV + 3 * CLK_DIV;
  localparam int N_CMDS   = 1 + 2 + 8 + 10 + 40;  // commands issued over all tests.

  logic       clk;
  logic       rst_n;
  spi_cmd_t   cmd_in;
  logic       cmd_vld;
  logic       cmd_rdy;
  spi_rdata_t read_data;
  logic       read_vld;
  logic       read_rdy;
  logic       sclk;
  logic       cs_n;
  logic       mosi;
  logic       miso;

  int unsigned seed;
  spi_cmd_t    exp_cmds[$];
  spi_cmd_t    rx_cmds[$];
  spi_rdata_t  exp_reads[$];
  spi_rdata_t  rx_reads[$];
  spi_rdata_t  ref_regs [8];
  spi_rdata_t  slv_regs [8];
  spi_cmd_t    slv_sr;
  spi_rdata_t  slv_out;
  int          slv_bits = 0;

  spi_master #(
    .CLK_DIV     (CLK_DIV),
    .QUEUE_DEPTH (4)
  ) DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_data (read_data),
    .read_vld  (read_vld),
    .read_rdy  (read_rdy),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("ERR %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("Test FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  always @(DUT.u_props.fail_count)
    if (DUT.u_props.fail_count != 0)
    begin
      $display("a bound protocol assertion failed at %0t ns", $time);
      $display("Test FAILED");
      $fatal(1, "assertion failed");
    end

  // ==========================================================================
  // mode 0 slave model
  // ==========================================================================

  always @(negedge cs_n)
    slv_bits = 0;

  always @(posedge sclk)
    if (!cs_n)
    begin
      if (slv_bits < CMD_WIDTH)
        slv_sr = {slv_sr[CMD_WIDTH-2:0], mosi};
      slv_bits++;
      if (slv_bits == CMD_WIDTH)
        slv_out = slv_regs[slv_sr[10:8]];  // byte for a read tail.
    end

  always @(negedge sclk)
    if (!cs_n && (slv_bits >= CMD_WIDTH) && !slv_sr[RW_BIT])
    begin
      miso    = slv_out[7];
      slv_out = {slv_out[6:0], 1'b0};
    end

  always @(posedge cs_n)
    if (rst_n === 1'b1)
    begin
      check_value(slv_bits, slv_sr[RW_BIT] ? 12 : 20, "bits in frame");
      if (slv_sr[RW_BIT])
        slv_regs[slv_sr[10:8]] = slv_sr[7:0];
      rx_cmds.push_back(slv_sr);
    end

  always @(posedge clk)
    if (rst_n && read_vld && read_rdy)
      rx_reads.push_back(read_data);

  // ==========================================================================
  // host side
  // ==========================================================================

  task automatic issue_cmd(input spi_cmd_t c);
    exp_cmds.push_back(c);
    if (c[RW_BIT])
      ref_regs[c[10:8]] = c[7:0];
    else
      exp_reads.push_back(ref_regs[c[10:8]]);
    cmd_in  = c;
    cmd_vld = 1'b1;
    @(posedge clk);
    while (!cmd_rdy)
      @(posedge clk);
    #2;
    cmd_vld = 1'b0;
  endtask

  task automatic drain_and_compare();
    while ((rx_cmds.size() < exp_cmds.size()) || (rx_reads.size() < exp_reads.size()))
      @(posedge clk);
    repeat (4 * CLK_DIV) @(posedge clk);
    check_value(rx_cmds.size(), exp_cmds.size(), "frames at slave");
    check_value(rx_reads.size(), exp_reads.size(), "read transfers");
    while (exp_cmds.size() > 0)
      check_value(rx_cmds.pop_front(), exp_cmds.pop_front(), "command at slave");
    while (exp_reads.size() > 0)
      check_value(rx_reads.pop_front(), exp_reads.pop_front(), "read_data");
    #2;
  endtask

  task automatic reset_values();
    check_value(cs_n, 1'b1, "cs_n after reset");
    check_value(sclk, 1'b0, "sclk after reset");
    check_value(mosi, 1'b0, "mosi after reset");
    check_value(read_vld, 1'b0, "read_vld after reset");
    check_value(cmd_rdy, 1'b1, "cmd_rdy after reset");
  endtask

  task automatic single_write();
    issue_cmd(12'hB3C);  // write 3c to reg 3.
    drain_and_compare();
    check_value(slv_regs[3], 8'h3C, "slave reg 3");
  endtask

  task automatic write_then_read();
    issue_cmd(12'hDC7);
    issue_cmd(12'h500);
    drain_and_compare();
  endtask

  task automatic mixed_burst();
    issue_cmd(12'hA11);
    issue_cmd(12'h200);
    issue_cmd(12'hF5E);
    issue_cmd(12'h700);
    issue_cmd(12'h100);  // still the fill value.
    issue_cmd(12'hA99);
    issue_cmd(12'h2FF);
    issue_cmd(12'hC3C);
    drain_and_compare();
  endtask

  task automatic read_backpressure();
    read_rdy = 1'b0;
    fork
      for (int i = 0; i < 10; i++)
        issue_cmd({1'b0, i[2:0], 8'h00});
      begin
        // four reads fill the read queue and the engine stalls.
        while (rx_cmds.size() < 4)
          @(posedge clk);
        repeat (2 * READ_CYC) @(posedge clk);
        check_value(rx_cmds.size(), 4, "frames while blocked");
        check_value(cmd_rdy, 1'b0, "cmd_rdy while blocked");
        #2;
        read_rdy = 1'b1;
      end
    join
    drain_and_compare();
  endtask

  task automatic random_traffic();
    spi_cmd_t c;
    for (int i = 0; i < 40; i++)
    begin
      c = spi_cmd_t'($urandom);
      issue_cmd(c);
    end
    drain_and_compare();
  endtask

  initial
  begin
    #(N_CMDS * READ_CYC * 3 * 20);
    $display("timeout: transfers did not finish in the expected time");
    $display("Test FAILED");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    seed = 32'h2352eb00;
    void'($urandom(seed));
    rst_n    = 1'b0;
    cmd_in   = '0;
    cmd_vld  = 1'b0;
    read_rdy = 1'b1;
    miso     = 1'b0;
    for (int i = 0; i < 8; i++)
    begin
      slv_regs[i] = 8'hA0 + i;
      ref_regs[i] = 8'hA0 + i;
    end
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    reset_values();
    single_write();
    write_then_read();
    mixed_burst();
    read_backpressure();
    random_traffic();
    $display("Test OK");
    $finish;
  end

endmodule
